// ==== compile.f ====
hw/starPkg.sv
hw/pixelPosition.sv
hw/windowBuffer.sv
hw/starDetect.sv
hw/recordWriter.sv
hw/starExtract.sv
verif/starExtractChk.sv
verif/starExtractTb.sv

// ==== hw/pixelPosition.sv ====
`timescale 1ns/1ns
`default_nettype none

module pixelPosition
	import starPkg::*;
#(
	parameter int frameWidth = 1280,
	parameter int frameHeight = 1024
)
(
	input wire clk,
	input wire rst,
	input wire frameVal,
	input wire lineVal,
	output logic pixValid,
	output coord_t row,
	output coord_t col,
	output logic frameStart,
	output logic frameEnd
);

	localparam coord_t lastCol = coord_t'(frameWidth - 1);
	localparam coord_t lastRow = coord_t'(frameHeight - 1);

	logic fvPrev;                           // frameVal one clock back

	// Pixel strobe straight from the camera qualifiers
	assign pixValid = frameVal & lineVal;

	// Frame edges
	assign frameStart = frameVal & ~fvPrev;
	assign frameEnd = ~frameVal & fvPrev;

	always_ff @(posedge clk)
	begin
		if (rst)
			fvPrev <= 1'b0;
		else
			fvPrev <= frameVal;
	end

	//////////////////////////////////////////////////////////////////////
	// Position of the pixel on the bus now
	//////////////////////////////////////////////////////////////////////

	// Held at zero between frames, so the first pixel after frameStart is (0,0)
	always_ff @(posedge clk)
	begin
		if (rst || !frameVal)
		begin
			row <= '0;
			col <= '0;
		end
		else if (pixValid)
		begin
			if (col == lastCol)
			begin
				col <= '0;                      // End of line
				if (row != lastRow)
					row <= row + 1'b1;          // Saturates on the last row
			end
			else
				col <= col + 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== hw/recordWriter.sv ====
`timescale 1ns/1ns
`default_nettype none

module recordWriter
	import starPkg::*;
(
	input wire clk,
	input wire rst,
	input wire candValid,
	input wire coord_t candRow,
	input wire coord_t candCol,
	input wire sum_t ySum,
	input wire sum_t xSum,
	input wire sum_t cenSum,
	input wire [bgW-1:0] bgSum,
	input wire frameStart,
	input wire frameEnd,
	output logic writerBusy,
	output logic recWe,
	output logic [recAddrW-1:0] recAddr,
	output sum_t recData,
	output logic [recAddrW-1:0] starCount,
	output logic frameDone
);

	localparam logic [2:0] lastIdx = 3'(recWords);

	logic [2:0] wordIdx;                    // Next word to send, 1..4
	logic [recAddrW-1:0] wrPtr;             // Address of the next word
	logic capture, emit;
	logic endDly, donePend;

	// Latched candidate
	coord_t colR;
	sum_t ySumR, xSumR, cenSumR;
	logic [bgW-1:0] bgR;
	sum_t bg21, bg63, wordMux;

	// Corrected value, floored at zero
	function automatic sum_t clampSub(input sum_t a, input sum_t b);
		return (a > b) ? a - b : '0;
	endfunction

	assign capture = candValid && !recWe;
	assign emit = capture || (recWe && (wordIdx != lastIdx));
	assign writerBusy = candValid | recWe;  // Capture cycle through last word

	//////////////////////////////////////////////////////////////////////
	// Background scaling
	//////////////////////////////////////////////////////////////////////

	// 21/16 and 63/16 of the ring sum
	assign bg21 = sum_t'(bgR) + sum_t'(bgR >> 2) + sum_t'(bgR >> 4);
	assign bg63 = (sum_t'(bgR) << 2) - sum_t'(bgR >> 4);

	always_comb
	begin
		case (wordIdx)
			3'd1: wordMux = sum_t'(colR);
			3'd2: wordMux = clampSub(ySumR, bg63);
			3'd3: wordMux = clampSub(xSumR, bg63);
			3'd4: wordMux = clampSub(cenSumR, bg21);
			default: wordMux = '0;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Sequencer and frame status
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			recWe <= 1'b0;
			wordIdx <= '0;
			wrPtr <= '0;
			starCount <= '0;
			endDly <= 1'b0;
			donePend <= 1'b0;
			frameDone <= 1'b0;
		end
		else
		begin
			if (capture)
			begin
				recWe <= 1'b1;              // Row word goes out now
				wordIdx <= 3'd1;
			end
			else if (recWe)
			begin
				if (wordIdx == lastIdx)
				begin
					recWe <= 1'b0;
					wordIdx <= '0;
				end
				else
					wordIdx <= wordIdx + 1'b1;
			end
			if (frameStart)
				wrPtr <= '0;                // Record area restarts each frame
			else if (emit)
				wrPtr <= wrPtr + 1'b1;
			if (frameStart)
				starCount <= '0;
			else if (capture)
				starCount <= starCount + 1'b1;
			// One clock of slack lets the last window reach the writer
			endDly <= frameEnd;
			frameDone <= 1'b0;
			if ((donePend || endDly) && !writerBusy)
			begin
				frameDone <= 1'b1;
				donePend <= 1'b0;
			end
			else if (endDly)
				donePend <= 1'b1;           // Wait for the record to drain
		end
	end

	// Word registers
	always_ff @(posedge clk)
	begin
		if (capture)
		begin
			colR <= candCol;
			ySumR <= ySum;
			xSumR <= xSum;
			cenSumR <= cenSum;
			bgR <= bgSum;
		end
		if (emit)
		begin
			recAddr <= wrPtr;
			recData <= capture ? sum_t'(candRow) : wordMux;
		end
	end

endmodule

`default_nettype wire

// ==== hw/starDetect.sv ====
`timescale 1ns/1ns
`default_nettype none

module starDetect
	import starPkg::*;
(
	input wire clk,
	input wire rst,
	input wire pixel_t [windowSize-1:0][windowSize-1:0] win,
	input wire winValid,
	input wire coord_t winRow,
	input wire coord_t winCol,
	input wire pixel_t cutoff,
	input wire writerBusy,
	output logic candValid,
	output coord_t candRow,
	output coord_t candCol,
	output sum_t ySum,
	output sum_t xSum,
	output sum_t cenSum,
	output logic [bgW-1:0] bgSum
);

	//////////////////////////////////////////////////////////////////////
	// Brightness and local maximum
	//////////////////////////////////////////////////////////////////////

	pixel_t ctr, up, dn, lf, rt;
	logic bright, locMax, hit;

	assign ctr = win[3][3];
	assign up = win[2][3];
	assign dn = win[4][3];
	assign lf = win[3][2];
	assign rt = win[3][4];

	// Centre and one 4-neighbour over the threshold
	assign bright = (ctr > cutoff) &&
		((up > cutoff) || (dn > cutoff) || (lf > cutoff) || (rt > cutoff));

	// Ties win toward up and left only, so a plateau yields one star
	assign locMax = (ctr >= lf) && (ctr >= up) && (ctr > dn) && (ctr > rt);

	assign hit = winValid && !writerBusy && bright && locMax;

	//////////////////////////////////////////////////////////////////////
	// Sums
	//////////////////////////////////////////////////////////////////////

	sum_t rowSum [1:5];                     // Masked pixels per row
	sum_t colSum [1:5];                     // Masked pixels per column
	sum_t cenNext, xNext, yNext;
	logic [bgW-1:0] bgNext;

	// Weights 1..5 from shifts and adds
	function automatic sum_t weigh(input sum_t s1, input sum_t s2, input sum_t s3,
		input sum_t s4, input sum_t s5);
		return s1 + (s2 << 1) + (s3 << 1) + s3 + (s4 << 2) + (s5 << 2) + s5;
	endfunction

	// Inner 5x5 less its corners, 21 pixels
	always_comb
	begin
		for (int i = 1; i <= 5; i++)
		begin
			rowSum[i] = '0;
			colSum[i] = '0;
		end
		for (int r = 1; r <= 5; r++)
		begin
			for (int c = 1; c <= 5; c++)
			begin
				if (!((r == 1 || r == 5) && (c == 1 || c == 5)))
				begin
					rowSum[r] = rowSum[r] + sum_t'(win[r][c]);
					colSum[c] = colSum[c] + sum_t'(win[r][c]);
				end
			end
		end
	end

	assign cenNext = rowSum[1] + rowSum[2] + rowSum[3] + rowSum[4] + rowSum[5];
	assign xNext = weigh(colSum[1], colSum[2], colSum[3], colSum[4], colSum[5]);
	assign yNext = weigh(rowSum[1], rowSum[2], rowSum[3], rowSum[4], rowSum[5]);

	// Background ring, 16 pixels around the centroid mask
	always_comb
	begin
		bgNext = bgW'(win[1][1]) + bgW'(win[1][5]) + bgW'(win[5][1]) + bgW'(win[5][5]);
		for (int k = 2; k <= 4; k++)
		begin
			bgNext = bgNext + bgW'(win[0][k]) + bgW'(win[6][k]);   // Top and bottom
			bgNext = bgNext + bgW'(win[k][0]) + bgW'(win[k][6]);   // Left and right
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Candidate register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
			candValid <= 1'b0;
		else
			candValid <= hit;               // One-cycle strobe
	end

	always_ff @(posedge clk)
	begin
		if (hit)
		begin
			candRow <= winRow;
			candCol <= winCol;
			ySum <= yNext;
			xSum <= xNext;
			cenSum <= cenNext;
			bgSum <= bgNext;
		end
	end

endmodule

`default_nettype wire

// ==== hw/starExtract.sv ====
`timescale 1ns/1ns
`default_nettype none

module starExtract
	import starPkg::*;
#(
	parameter int frameWidth = 1280,
	parameter int frameHeight = 1024
)
(
	input wire clk,
	input wire rst,
	input wire pixel_t pixel,               // Camera data
	input wire frameVal,
	input wire lineVal,
	input wire pixel_t cutoff,              // Brightness threshold
	output logic recWe,                     // Record memory write port
	output logic [recAddrW-1:0] recAddr,
	output sum_t recData,
	output logic [recAddrW-1:0] starCount,
	output logic frameDone
);

	//////////////////////////////////////////////////////////////////////
	// Internal nets
	//////////////////////////////////////////////////////////////////////

	logic pixValid, frameStart, frameEnd;
	coord_t row, col;
	pixel_t [windowSize-1:0][windowSize-1:0] win;
	logic winValid;
	coord_t winRow, winCol;
	logic candValid, writerBusy;
	coord_t candRow, candCol;
	sum_t ySum, xSum, cenSum;
	logic [bgW-1:0] bgSum;

	// Stream position and frame edges
	pixelPosition #(
		.frameWidth(frameWidth),
		.frameHeight(frameHeight)
	) uPos (
		.clk(clk),
		.rst(rst),
		.frameVal(frameVal),
		.lineVal(lineVal),
		.pixValid(pixValid),
		.row(row),
		.col(col),
		.frameStart(frameStart),
		.frameEnd(frameEnd)
	);

	// Line buffer and 7x7 neighbourhood
	windowBuffer #(
		.frameWidth(frameWidth)
	) uWin (
		.clk(clk),
		.rst(rst),
		.pixValid(pixValid),
		.pixel(pixel),
		.row(row),
		.col(col),
		.win(win),
		.winValid(winValid),
		.winRow(winRow),
		.winCol(winCol)
	);

	starDetect uDet (
		.clk(clk),
		.rst(rst),
		.win(win),
		.winValid(winValid),
		.winRow(winRow),
		.winCol(winCol),
		.cutoff(cutoff),
		.writerBusy(writerBusy),
		.candValid(candValid),
		.candRow(candRow),
		.candCol(candCol),
		.ySum(ySum),
		.xSum(xSum),
		.cenSum(cenSum),
		.bgSum(bgSum)
	);

	// Five-word record out to memory
	recordWriter uRec (
		.clk(clk),
		.rst(rst),
		.candValid(candValid),
		.candRow(candRow),
		.candCol(candCol),
		.ySum(ySum),
		.xSum(xSum),
		.cenSum(cenSum),
		.bgSum(bgSum),
		.frameStart(frameStart),
		.frameEnd(frameEnd),
		.writerBusy(writerBusy),
		.recWe(recWe),
		.recAddr(recAddr),
		.recData(recData),
		.starCount(starCount),
		.frameDone(frameDone)
	);

endmodule

`default_nettype wire

// ==== hw/starPkg.sv ====
`default_nettype none

package starPkg;

	//////////////////////////////////////////////////////////////////////
	// Pixel stream
	//////////////////////////////////////////////////////////////////////

	localparam int pixelW = 10;             // Sensor output depth
	typedef logic [pixelW-1:0] pixel_t;

	// Row or column number, 1280 columns need 11 bits
	localparam int coordW = 11;
	typedef logic [coordW-1:0] coord_t;

	//////////////////////////////////////////////////////////////////////
	// Neighbourhood and sums
	//////////////////////////////////////////////////////////////////////

	localparam int windowSize = 7;          // Window edge in pixels

	// Weighted sums peak at 63 x 1023, so 16 bits
	localparam int sumW = 16;
	typedef logic [sumW-1:0] sum_t;         // Also one record word

	// Background ring is 16 pixels, 16 x 1023 fits 14 bits
	localparam int bgW = 14;

	//////////////////////////////////////////////////////////////////////
	// Record memory
	//////////////////////////////////////////////////////////////////////

	// Row, col, y sum, x sum, centroid sum
	localparam int recWords = 5;
	localparam int recAddrW = 18;           // Record memory address width

endpackage

`default_nettype wire

// ==== hw/windowBuffer.sv ====
`timescale 1ns/1ns
`default_nettype none

module windowBuffer
	import starPkg::*;
#(
	parameter int frameWidth = 1280
)
(
	input wire clk,
	input wire rst,
	input wire pixValid,
	input wire pixel_t pixel,
	input wire coord_t row,
	input wire coord_t col,
	output pixel_t [windowSize-1:0][windowSize-1:0] win,   // [row][col]
	output logic winValid,
	output coord_t winRow,
	output coord_t winCol
);

	localparam int lineRows = windowSize - 1;              // Delay lines needed
	localparam int addrW = (frameWidth > 1) ? $clog2(frameWidth) : 1;
	localparam coord_t reach = coord_t'(windowSize - 1);   // Offset to top-left

	//////////////////////////////////////////////////////////////////////
	// Row delay lines
	//////////////////////////////////////////////////////////////////////

	// Each line holds one image row, addressed by column
	pixel_t lineMem [lineRows][frameWidth];
	pixel_t tap [windowSize];               // tap[k] is k rows older than pixel
	logic [addrW-1:0] lineAddr;

	assign lineAddr = col[addrW-1:0];

	always_comb
	begin
		tap[0] = pixel;                     // Newest row comes straight in
		for (int k = 1; k < windowSize; k++)
			tap[k] = lineMem[k - 1][lineAddr];
	end

	// Read old value, write one row newer at the same column
	always_ff @(posedge clk)
	begin
		if (pixValid)
		begin
			for (int k = 0; k < lineRows; k++)
				lineMem[k][lineAddr] <= tap[k];
		end
	end

	//////////////////////////////////////////////////////////////////////
	// 7x7 window
	//////////////////////////////////////////////////////////////////////

	// Column taps enter on the right, oldest row at the top
	always_ff @(posedge clk)
	begin
		if (pixValid)
		begin
			for (int r = 0; r < windowSize; r++)
			begin
				for (int c = 0; c < windowSize - 1; c++)
					win[r][c] <= win[r][c + 1];
				win[r][windowSize - 1] <= tap[windowSize - 1 - r];
			end
		end
	end

	// Full neighbourhood once six rows and six columns lie behind
	always_ff @(posedge clk)
	begin
		if (rst)
			winValid <= 1'b0;
		else
			winValid <= pixValid && (row >= reach) && (col >= reach);
	end

	// Top-left corner of the window
	always_ff @(posedge clk)
	begin
		if (pixValid)
		begin
			winRow <= row - reach;
			winCol <= col - reach;
		end
	end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build the star extractor testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module starExtractTb -f compile.f -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

simOut=$(./obj_dir/VstarExtractTb)
simStatus=$?
echo "$simOut"
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if echo "$simOut" | grep -q "ALL CHECKS PASSED"; then
	exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// ==== verif/starExtractChk.sv ====
`timescale 1ns/1ns
`default_nettype none

module starExtractChk
	import starPkg::*;
(
	input wire clk,
	input wire rst,
	input wire recWe,
	input wire [recAddrW-1:0] recAddr,
	input wire frameStart,
	input wire frameDone
);

	localparam logic [recAddrW-1:0] addrStep = 1;

	logic [2:0] runLen;                     // Writes so far in the current burst
	logic [recAddrW-1:0] prevAddr;          // Address of the last word written
	logic wroteOnce;                        // A word already went out this frame

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			runLen <= 3'd0;
			wroteOnce <= 1'b0;
		end
		else
		begin
			runLen <= recWe ? runLen + 3'd1 : 3'd0;
			if (frameStart)
				wroteOnce <= 1'b0;
			else if (recWe)
				wroteOnce <= 1'b1;
		end
		if (recWe)
			prevAddr <= recAddr;
	end

	//////////////////////////////////////////////////////////////////////
	// Record port rules
	//////////////////////////////////////////////////////////////////////

	// Never a sixth word in one burst
	burstMax: assert property (@(posedge clk) disable iff (rst) recWe |-> runLen < 3'd5)
		else $error("record burst runs past five words");

	// A burst that ends has exactly five words
	burstLen: assert property (@(posedge clk) disable iff (rst)
		(!recWe && runLen != 3'd0) |-> runLen == 3'd5)
		else $error("record burst ended after %0d words", runLen);

	addrSeq: assert property (@(posedge clk) disable iff (rst)
		(recWe && wroteOnce) |-> recAddr == prevAddr + addrStep)
		else $error("record address skipped, %0d after %0d", recAddr, prevAddr);

	// Done only once the writer has drained
	doneQuiet: assert property (@(posedge clk) disable iff (rst) !(frameDone && recWe))
		else $error("frame done raised during a record write");

endmodule

bind starExtract starExtractChk uChk (
	.clk(clk),
	.rst(rst),
	.recWe(recWe),
	.recAddr(recAddr),
	.frameStart(frameStart),
	.frameDone(frameDone)
);

`default_nettype wire

// ==== verif/starExtractTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module starExtractTb
	import starPkg::*;
();

	localparam int width = 32;
	localparam int height = 20;
	localparam int lineGap = 4;             // Idle cycles between lines
	localparam int frameGap = 10;           // Idle cycles after a frame
	localparam int thresh = 300;            // Brightness cutoff for every frame
	localparam int frameCycles = height * (width + lineGap) + frameGap;
	localparam int cycleLimit = 20 + 3 * (frameCycles + 20) + 200;   // Three frames plus slack

	logic clk = 1'b0;
	logic rst;
	pixel_t pixel, cutoff;
	logic frameVal, lineVal;
	logic recWe, frameDone;
	logic [recAddrW-1:0] recAddr, starCount;
	sum_t recData;

	int img [height][width];                // Frame about to be streamed
	sum_t expQ [$];                         // Expected record words, in order
	sum_t expWord;
	int expStars = 0;
	int wordCnt = 0;                        // Words seen in the current frame
	int framesDone = 0;
	int mismatches = 0;
	int failures = 0;
	int cycles;

	always #10 clk = ~clk;

	starExtract #(
		.frameWidth(width),
		.frameHeight(height)
	) UUT (
		.clk(clk),
		.rst(rst),
		.pixel(pixel),
		.frameVal(frameVal),
		.lineVal(lineVal),
		.cutoff(cutoff),
		.recWe(recWe),
		.recAddr(recAddr),
		.recData(recData),
		.starCount(starCount),
		.frameDone(frameDone)
	);

	//////////////////////////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////////////////////////

	// 21-pixel centroid mask, window coordinates
	function automatic bit inMask(input int i, input int j);
		return i >= 1 && i <= 5 && j >= 1 && j <= 5 && !((i == 1 || i == 5) && (j == 1 || j == 5));
	endfunction

	// 16-pixel background ring
	function automatic bit inRing(input int i, input int j);
		return ((i == 0 || i == 6) && j >= 2 && j <= 4) || ((j == 0 || j == 6) && i >= 2 && i <= 4)
			|| ((i == 1 || i == 5) && (j == 1 || j == 5));
	endfunction

	// Scans the frame in raster order, queues the records, returns the star count
	function automatic int modelFrame(input int cut);
		int n, c, p, cen, xs, ys, bg, bg21, bg63;
		bit hit;
		n = 0;
		for (int r = 3; r <= height - 4; r++)
		begin
			for (int k = 3; k <= width - 4; k++)
			begin
				c = img[r][k];
				hit = (c > cut) && (img[r-1][k] > cut || img[r+1][k] > cut ||
					img[r][k-1] > cut || img[r][k+1] > cut);
				hit = hit && c >= img[r][k-1] && c >= img[r-1][k];   // Ties allowed up and left
				hit = hit && c > img[r+1][k] && c > img[r][k+1];
				if (hit)
				begin
					cen = 0;
					xs = 0;
					ys = 0;
					bg = 0;
					for (int i = 0; i < 7; i++)
					begin
						for (int j = 0; j < 7; j++)
						begin
							p = img[r-3+i][k-3+j];
							if (inMask(i, j))
							begin
								cen += p;
								xs += j * p;    // Column index weight
								ys += i * p;    // Row index weight
							end
							else if (inRing(i, j))
								bg += p;
						end
					end
					bg21 = bg + bg / 4 + bg / 16;
					bg63 = 4 * bg - bg / 16;
					expQ.push_back(sum_t'(r - 3));
					expQ.push_back(sum_t'(k - 3));
					expQ.push_back(sum_t'((ys > bg63) ? ys - bg63 : 0));   // Floor at zero
					expQ.push_back(sum_t'((xs > bg63) ? xs - bg63 : 0));
					expQ.push_back(sum_t'((cen > bg21) ? cen - bg21 : 0));
					n++;
				end
			end
		end
		return n;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Frame content
	//////////////////////////////////////////////////////////////////////

	task automatic fillBackground(input int maxLevel);
		for (int r = 0; r < height; r++)
			for (int k = 0; k < width; k++)
				img[r][k] = int'($urandom_range(maxLevel - 1, 0));
	endtask

	// Six cells, 9 columns apart, row jittered inside two bands
	function automatic int cellRow(input int idx);
		return ((idx < 3) ? 4 : 13) + int'($urandom_range(2, 0));
	endfunction

	function automatic int cellCol(input int idx);
		return 4 + 9 * (idx % 3);
	endfunction

	// Flat 2x2 block, only its bottom-right pixel qualifies
	task automatic putPlateau(input int r, input int c, input int v);
		img[r][c] = v;
		img[r][c+1] = v;
		img[r+1][c] = v;
		img[r+1][c+1] = v;
	endtask

	// Peak with four dimmer neighbours over the cutoff
	task automatic putStar(input int r, input int c);
		int peak;
		peak = thresh + 20 + int'($urandom_range(400, 0));
		img[r][c] = peak;
		img[r-1][c] = thresh + 1 + int'($urandom_range(peak - thresh - 2, 0));
		img[r+1][c] = thresh + 1 + int'($urandom_range(peak - thresh - 2, 0));
		img[r][c-1] = thresh + 1 + int'($urandom_range(peak - thresh - 2, 0));
		img[r][c+1] = thresh + 1 + int'($urandom_range(peak - thresh - 2, 0));
	endtask

	// Faint star in a bright ring, every corrected word clamps
	task automatic putRingStar(input int r, input int c);
		for (int i = 0; i < 7; i++)
			for (int j = 0; j < 7; j++)
				if (inRing(i, j))
					img[r-3+i][c-3+j] = thresh - 1;
		img[r][c] = thresh + 2;
		img[r-1][c] = thresh + 1;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////////////////////////

	task automatic sendFrame();
		for (int r = 0; r < height; r++)
		begin
			for (int k = 0; k < width; k++)
			begin
				@(posedge clk);
				frameVal <= 1'b1;
				lineVal <= 1'b1;
				pixel <= pixel_t'(img[r][k]);
			end
			repeat (lineGap)
			begin
				@(posedge clk);
				lineVal <= 1'b0;
			end
		end
		@(posedge clk);
		frameVal <= 1'b0;
	endtask

	task automatic runFrame();
		int target;
		expStars = modelFrame(thresh);
		target = framesDone + 1;
		sendFrame();
		while (framesDone < target)
			@(negedge clk);                 // Cycle counter guards this wait
		repeat (frameGap) @(posedge clk);
	endtask

	task automatic report();
		$display("Error counts: %0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches == 0 && failures == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	endtask

	initial
	begin
		void'($urandom(32'h255f_941f));
		rst = 1'b1;
		pixel = '0;
		frameVal = 1'b0;
		lineVal = 1'b0;
		cutoff = pixel_t'(thresh);
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		repeat (4) @(posedge clk);
		fillBackground(thresh);             // Dark frame, nothing over the cutoff
		runFrame();
		fillBackground(200);
		for (int i = 0; i < 4; i++)
			putPlateau(cellRow(i), cellCol(i), thresh + 100 + int'($urandom_range(500, 0)));
		img[cellRow(4)][cellCol(4)] = thresh + 200;   // Lone spike, dark neighbours
		begin
			int tr;
			tr = cellRow(5);
			img[tr][cellCol(5)] = thresh + 150;       // Tie with right neighbour
			img[tr][cellCol(5) + 1] = thresh + 150;
		end
		runFrame();
		fillBackground(120);
		for (int i = 0; i < 5; i++)
			putStar(cellRow(i), cellCol(i));
		putRingStar(cellRow(5), cellCol(5));
		runFrame();
		report();
	end

	//////////////////////////////////////////////////////////////////////
	// Compare and timeout
	//////////////////////////////////////////////////////////////////////

	function automatic string fieldName(input int idx);
		case (idx)
			0: return "row";
			1: return "column";
			2: return "y sum";
			3: return "x sum";
			default: return "centroid sum";
		endcase
	endfunction

	// Outputs are registered, so the falling edge sees them settled
	always @(negedge clk)
	begin
		if (!rst && recWe)
		begin
			assert (expQ.size() > 0)
			else
			begin
				$display("Unexpected record word at %0t ns, no star left in this frame", $time);
				failures++;
			end
			if (expQ.size() > 0)
			begin
				expWord = expQ.pop_front();
				assert (recData == expWord)
				else
				begin
					$display("Mismatch at %0t ns: %s word is %0d, expected %0d", $time,
						fieldName(wordCnt % recWords), recData, expWord);
					mismatches++;
				end
			end
			assert (recAddr == recAddrW'(wordCnt))
			else
			begin
				$display("Mismatch at %0t ns: record address is %0d, expected %0d", $time,
					recAddr, wordCnt);
				mismatches++;
			end
			wordCnt++;
		end
		if (!rst && frameDone)
		begin
			assert (expQ.size() == 0)
			else
			begin
				$display("Frame done at %0t ns with %0d record words never written", $time,
					expQ.size());
				failures++;
			end
			assert (starCount == recAddrW'(expStars))
			else
			begin
				$display("Mismatch at %0t ns: star count is %0d, expected %0d", $time,
					starCount, expStars);
				mismatches++;
			end
			expQ.delete();
			wordCnt = 0;                    // Addresses restart next frame
			framesDone++;
		end
	end

	initial
	begin
		cycles = 0;
		while (cycles < cycleLimit)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout after %0d cycles, a frame never completed", cycles);
		failures++;
		report();
	end

endmodule

`default_nettype wire
